// ==== bench/biu_wb_tb.sv ====
/* Directed tests of the BIU against a byte reference memory. Random traffic stays in
   the low 256 bytes, which are filled first, because SRAM contents start unknown */
`timescale 1ns/1ps
`include "biu_settings.svh"

module biu_wb_tb;

    localparam int DEPTH          = `REQ_QUEUE_DEPTH;
    localparam int MEM_BYTES      = `SRAM_WORDS * (`WB_DATA_WIDTH / 8);
    localparam int FILL_BYTES     = 256;
    localparam int MAX_REQS       = 128;
    localparam int WAIT_LIMIT     = 400;
    // About 75 requests at up to 40 cycles each, plus margin
    localparam int TIMEOUT_CYCLES = 4000;

    logic              clk;
    logic              reset;
    logic              i_req_push;
    biu_pkg::biu_req_t i_req;
    logic              o_credit;
    logic              o_rsp_valid;
    biu_pkg::biu_rsp_t o_rsp;

    logic [7:0]        ref_mem [MEM_BYTES];
    biu_pkg::biu_rsp_t exp_rsp [MAX_REQS];
    int                n_pushed;
    int                n_rsp;
    int                n_credit;
    int                min_credits;
    int                errors;
    int                cycle_count;

    tb_clock clock0 (
        .o_clk   (clk),
        .o_reset (reset)
    );

    biu_wb_top dut0 (
        .i_wb_clk    (clk),
        .i_reset     (reset),
        .i_req_push  (i_req_push),
        .i_req       (i_req),
        .o_credit    (o_credit),
        .o_rsp_valid (o_rsp_valid),
        .o_rsp       (o_rsp)
    );

    task automatic check_rsp(input string name, input biu_pkg::biu_rsp_t exp,
                             input biu_pkg::biu_rsp_t act);
        if (act !== exp) begin
            $display("CHECK FAILED at %0t: %s expected %h, got %h", $time, name,
                     exp.data, act.data);
            errors++;
        end
    endtask

    task automatic check_credit(input string name, input int exp, input int act);
        if (act != exp) begin
            $display("CHECK FAILED at %0t: %s expected %0d, got %0d", $time, name, exp, act);
            errors++;
        end
    endtask

    function automatic int credits_left();
        return DEPTH - n_pushed + n_credit;
    endfunction

    function automatic int beats_of(input biu_pkg::biu_len_t len);
        case (len)
            biu_pkg::BIU_LEN_4B: return 1;
            biu_pkg::BIU_LEN_8B: return 2;
            default:             return 4;
        endcase
    endfunction

    function automatic biu_pkg::biu_data_t rand_data();
        biu_pkg::biu_data_t d;
        for (int i = 0; i < 4; i++) begin
            d[i*32 +: 32] = $urandom();
        end
        return d;
    endfunction

    // Samples outputs mid-cycle, then returns 1 ns after the next rising edge
    task automatic next_cycle();
        @(negedge clk);
        if (o_credit === 1'b1) begin
            n_credit++;
        end
        if (o_rsp_valid === 1'b1) begin
            if (n_rsp >= n_pushed) begin
                $display("ERROR at %0t: response arrived with no request pending", $time);
                errors++;
            end else begin
                check_rsp("o_rsp", exp_rsp[n_rsp % MAX_REQS], o_rsp);
            end
            n_rsp++;
        end
        @(posedge clk);
        #1;
    endtask

    // Pushes one request and applies it to the reference memory in queue order
    task automatic send_req(input biu_pkg::biu_func_t func, input biu_pkg::biu_len_t len,
                            input biu_pkg::biu_addr_t addr, input biu_pkg::biu_sel_t sel,
                            input biu_pkg::biu_data_t data);
        biu_pkg::biu_rsp_t exp;
        int a;
        int k;
        while (credits_left() == 0) begin
            next_cycle();
        end
        exp = '0;
        for (int w = 0; w < beats_of(len); w++) begin
            for (int b = 0; b < 4; b++) begin
                k = 4 * w + b;
                a = (int'(addr) + k) % MEM_BYTES;
                if (func != biu_pkg::BIU_FUNC_WRITE) begin
                    exp.data[k*8 +: 8] = ref_mem[a];
                end
                if (func != biu_pkg::BIU_FUNC_READ && sel[k]) begin
                    ref_mem[a] = data[k*8 +: 8];
                end
            end
        end
        exp_rsp[n_pushed % MAX_REQS] = exp;
        i_req      = '{func: func, len: len, sel: sel, addr: addr, data: data};
        i_req_push = 1'b1;
        n_pushed++;
        if (credits_left() < min_credits) begin
            min_credits = credits_left();
        end
        next_cycle();
        i_req_push = 1'b0;
    endtask

    task automatic wait_done();
        int n;
        n = 0;
        while (n_rsp < n_pushed && n < WAIT_LIMIT) begin
            next_cycle();
            n++;
        end
        if (n_rsp < n_pushed) begin
            $display("ERROR at %0t: %0d response(s) never arrived", $time, n_pushed - n_rsp);
            errors++;
            n_rsp = n_pushed;
        end
    endtask

    task automatic test_reset_state();
        repeat (5) next_cycle();
        check_credit("o_credit pulses", 0, n_credit);
        check_credit("o_rsp_valid pulses", 0, n_rsp);
    endtask

    task automatic fill_memory();
        biu_pkg::biu_data_t d;
        int a;
        for (int blk = 0; blk < FILL_BYTES / 16; blk++) begin
            for (int k = 0; k < 16; k++) begin
                a = blk * 16 + k;
                d[k*8 +: 8] = 8'((a * 13) ^ (a >> 8) ^ 8'h5A);
            end
            send_req(biu_pkg::BIU_FUNC_WRITE, biu_pkg::BIU_LEN_16B, 16'(blk * 16), '1, d);
        end
        wait_done();
    endtask

    task automatic test_write_read();
        send_req(biu_pkg::BIU_FUNC_WRITE, biu_pkg::BIU_LEN_4B, 16'h0100, '1, rand_data());
        send_req(biu_pkg::BIU_FUNC_WRITE, biu_pkg::BIU_LEN_8B, 16'h0110, '1, rand_data());
        send_req(biu_pkg::BIU_FUNC_WRITE, biu_pkg::BIU_LEN_16B, 16'h0120, '1, rand_data());
        send_req(biu_pkg::BIU_FUNC_READ, biu_pkg::BIU_LEN_4B, 16'h0100, '1, '0);
        send_req(biu_pkg::BIU_FUNC_READ, biu_pkg::BIU_LEN_8B, 16'h0110, '1, '0);
        send_req(biu_pkg::BIU_FUNC_READ, biu_pkg::BIU_LEN_16B, 16'h0120, '1, '0);
        wait_done();
    endtask

    task automatic test_partial_write();
        send_req(biu_pkg::BIU_FUNC_WRITE, biu_pkg::BIU_LEN_16B, 16'h0040, 16'($urandom()),
                 rand_data());
        send_req(biu_pkg::BIU_FUNC_READ, biu_pkg::BIU_LEN_16B, 16'h0040, '1, '0);
        wait_done();
    endtask

    task automatic test_rmw();
        send_req(biu_pkg::BIU_FUNC_RMW, biu_pkg::BIU_LEN_16B, 16'h0080, 16'($urandom()),
                 rand_data());
        send_req(biu_pkg::BIU_FUNC_RMW, biu_pkg::BIU_LEN_4B, 16'h00C4, 16'($urandom()),
                 rand_data());
        send_req(biu_pkg::BIU_FUNC_READ, biu_pkg::BIU_LEN_16B, 16'h0080, '1, '0);
        send_req(biu_pkg::BIU_FUNC_READ, biu_pkg::BIU_LEN_4B, 16'h00C4, '1, '0);
        wait_done();
    endtask

    // The first request leaves the queue at once, so one extra push empties the credits
    task automatic test_credits();
        int rsp_start;
        rsp_start   = n_rsp;
        min_credits = DEPTH;
        for (int i = 0; i <= DEPTH; i++) begin
            send_req(biu_pkg::BIU_FUNC_READ, biu_pkg::BIU_LEN_16B, 16'(i * 16), '1, '0);
        end
        check_credit("lowest credit count", 0, min_credits);
        wait_done();
        repeat (2) next_cycle();
        check_credit("credit count after drain", DEPTH, credits_left());
        check_credit("responses to credit burst", DEPTH + 1, n_rsp - rsp_start);
    endtask

    task automatic test_random_mix();
        biu_pkg::biu_len_t  len;
        biu_pkg::biu_func_t func;
        int beats;
        for (int i = 0; i < 40; i++) begin
            func  = biu_pkg::biu_func_t'($urandom() % 3);
            len   = biu_pkg::biu_len_t'($urandom() % 3);
            beats = beats_of(len);
            send_req(func, len, 16'(($urandom() % (64 - beats + 1)) * 4), 16'($urandom()),
                     rand_data());
        end
        wait_done();
    endtask

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: run did not end within %0d cycles", TIMEOUT_CYCLES);
            $display("Test FAILED");
            $finish;
        end
    end

    initial begin
        i_req_push  = 1'b0;
        i_req       = '0;
        n_pushed    = 0;
        n_rsp       = 0;
        n_credit    = 0;
        min_credits = DEPTH;
        errors      = 0;
        cycle_count = 0;
        void'($urandom(8));
        wait (reset == 1'b0);
        @(posedge clk);
        #1;
        test_reset_state();
        fill_memory();
        test_write_read();
        test_partial_write();
        test_rmw();
        test_credits();
        test_random_mix();
        $display("Errors: %0d, requests: %0d, responses: %0d", errors, n_pushed, n_rsp);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// ==== bench/tb_clock.sv ====
/* Free-running 20 ns clock. Reset is held high over the first two rising edges */
`timescale 1ns/1ps

module tb_clock (
    output logic o_clk,
    output logic o_reset
);

    initial begin
        o_clk   = 1'b0;
        o_reset = 1'b1;
        forever #10 o_clk = ~o_clk;
    end

    initial begin
        repeat (2) @(posedge o_clk);
        #1 o_reset = 1'b0;
    end

endmodule

// ==== biu_wb_top.f ====
+incdir+hdl
hdl/biu_pkg.sv
hdl/biu_req_queue.sv
hdl/biu_controller_wb.sv
hdl/wb_sram.sv
hdl/biu_wb_top.sv
bench/tb_clock.sv
bench/biu_wb_tb.sv

// ==== hdl/biu_controller_wb.sv ====
/* Wishbone B4 master: linear incrementing bursts for reads and writes, classic
   read then write per word for RMW. Addresses are assumed word aligned */
`timescale 1ns/1ps
`include "biu_settings.svh"

module biu_controller_wb (
    input  logic              i_wb_clk,
    input  logic              i_reset,
    input  logic              i_req_valid,
    input  biu_pkg::biu_req_t i_req,
    input  biu_pkg::wb_s2m_t  i_wb,
    output logic              o_req_pop,
    output biu_pkg::wb_m2s_t  o_wb,
    output logic              o_rsp_valid,
    output biu_pkg::biu_rsp_t o_rsp
);

    localparam int WB_W     = `WB_DATA_WIDTH;
    localparam int WB_BYTES = WB_W / 8;
    localparam int WORDS    = `BIU_DATA_BYTES / WB_BYTES;
    localparam int IDX_W    = (WORDS > 1) ? $clog2(WORDS) : 1;
    localparam int CNT_W    = $clog2(WORDS + 1);

    typedef enum logic [2:0] {
        IDLE,
        SEND_REQ,
        RMW_READ,
        RMW_MODIFY,
        RMW_WRITE,
        DONE
    } state_t;

    state_t             state_r;
    biu_pkg::biu_req_t  req_r;
    biu_pkg::biu_data_t data_r;
    biu_pkg::wb_m2s_t   wb_r;
    logic [CNT_W-1:0]   cnt_r;
    logic [IDX_W-1:0]   idx_r;
    logic               rsp_valid_r;

    logic [CNT_W-1:0]   req_beats;
    logic [IDX_W-1:0]   idx_next;
    logic               last_beat;
    biu_pkg::wb_data_t  rmw_word;

    // Beats per request from the length code
    always_comb begin
        case (i_req.len)
            biu_pkg::BIU_LEN_4B: req_beats = CNT_W'(4 / WB_BYTES);
            biu_pkg::BIU_LEN_8B: req_beats = CNT_W'(8 / WB_BYTES);
            default:             req_beats = CNT_W'(16 / WB_BYTES);
        endcase
    end

    assign idx_next  = idx_r + IDX_W'(1);
    assign last_beat = (cnt_r == CNT_W'(1));

    // Merge the old word with the request bytes under the select
    always_comb begin
        biu_pkg::wb_data_t old_word;
        biu_pkg::wb_data_t new_word;
        biu_pkg::wb_sel_t  byte_sel;

        old_word = data_r[idx_r*WB_W +: WB_W];
        new_word = req_r.data[idx_r*WB_W +: WB_W];
        byte_sel = req_r.sel[idx_r*WB_BYTES +: WB_BYTES];
        for (int i = 0; i < WB_BYTES; i++) begin
            rmw_word[i*8 +: 8] = byte_sel[i] ? new_word[i*8 +: 8] : old_word[i*8 +: 8];
        end
    end

    assign o_req_pop = (state_r == IDLE) && i_req_valid;

    always_ff @(posedge i_wb_clk) begin
        if (i_reset) begin
            state_r     <= IDLE;
            wb_r.cyc    <= 1'b0;
            wb_r.stb    <= 1'b0;
            rsp_valid_r <= 1'b0;
        end else begin
            rsp_valid_r <= 1'b0;
            case (state_r)
                IDLE: begin
                    if (i_req_valid) begin
                        req_r     <= i_req;
                        data_r    <= '0;
                        cnt_r     <= req_beats;
                        idx_r     <= '0;
                        wb_r.cyc  <= 1'b1;
                        wb_r.stb  <= 1'b1;
                        wb_r.we   <= (i_req.func == biu_pkg::BIU_FUNC_WRITE);
                        wb_r.bte  <= biu_pkg::WB_BTE_LINEAR;
                        wb_r.addr <= i_req.addr;
                        wb_r.data <= i_req.data[WB_W-1:0];
                        if (i_req.func == biu_pkg::BIU_FUNC_RMW) begin
                            // Whole word is read first, the merge happens later
                            wb_r.cti <= biu_pkg::WB_CTI_CLASSIC;
                            wb_r.sel <= '1;
                            state_r  <= RMW_READ;
                        end else begin
                            wb_r.cti <= (req_beats == CNT_W'(1)) ?
                                        biu_pkg::WB_CTI_END_OF_BURST :
                                        biu_pkg::WB_CTI_INCREMENTING;
                            wb_r.sel <= i_req.sel[WB_BYTES-1:0];
                            state_r  <= SEND_REQ;
                        end
                    end
                end
                SEND_REQ: begin
                    if (i_wb.ack) begin
                        if (!wb_r.we) begin
                            data_r[idx_r*WB_W +: WB_W] <= i_wb.data;
                        end
                        cnt_r     <= cnt_r - CNT_W'(1);
                        idx_r     <= idx_next;
                        wb_r.addr <= wb_r.addr + biu_pkg::biu_addr_t'(WB_BYTES);
                        wb_r.sel  <= req_r.sel[idx_next*WB_BYTES +: WB_BYTES];
                        wb_r.data <= req_r.data[idx_next*WB_W +: WB_W];
                        // Next beat is the final one
                        wb_r.cti  <= (cnt_r == CNT_W'(2)) ? biu_pkg::WB_CTI_END_OF_BURST :
                                                            biu_pkg::WB_CTI_INCREMENTING;
                        if (last_beat) begin
                            wb_r.cyc    <= 1'b0;
                            wb_r.stb    <= 1'b0;
                            rsp_valid_r <= 1'b1;
                            state_r     <= DONE;
                        end
                    end
                end
                RMW_READ: begin
                    if (i_wb.ack) begin
                        data_r[idx_r*WB_W +: WB_W] <= i_wb.data;
                        wb_r.stb <= 1'b0;
                        state_r  <= RMW_MODIFY;
                    end
                end
                RMW_MODIFY: begin
                    wb_r.stb  <= 1'b1;
                    wb_r.we   <= 1'b1;
                    wb_r.data <= rmw_word;
                    state_r   <= RMW_WRITE;
                end
                RMW_WRITE: begin
                    if (i_wb.ack) begin
                        cnt_r     <= cnt_r - CNT_W'(1);
                        idx_r     <= idx_next;
                        wb_r.addr <= wb_r.addr + biu_pkg::biu_addr_t'(WB_BYTES);
                        wb_r.we   <= 1'b0;
                        if (last_beat) begin
                            wb_r.cyc    <= 1'b0;
                            wb_r.stb    <= 1'b0;
                            rsp_valid_r <= 1'b1;
                            state_r     <= DONE;
                        end else begin
                            state_r <= RMW_READ;
                        end
                    end
                end
                DONE: state_r <= IDLE;
                default: state_r <= IDLE;
            endcase
        end
    end

    assign o_wb        = wb_r;
    assign o_rsp_valid = rsp_valid_r;
    assign o_rsp.data  = data_r;

    a_stb_within_cyc: assert property (@(posedge i_wb_clk) disable iff (i_reset)
        o_wb.stb |-> o_wb.cyc);

    // Slave may stretch a beat, master must hold everything until ack
    a_hold_until_ack: assert property (@(posedge i_wb_clk) disable iff (i_reset)
        (o_wb.stb && !i_wb.ack) |=> $stable(o_wb));

endmodule

// ==== hdl/biu_pkg.sv ====
/* Request, response and Wishbone types shared by the BIU and the SRAM model.
   Only linear bursts and 4, 8 or 16 byte lengths are encoded */
`include "biu_settings.svh"

package biu_pkg;

    typedef logic [`BIU_ADDR_WIDTH-1:0]     biu_addr_t;
    typedef logic [`BIU_DATA_BYTES*8-1:0]   biu_data_t;
    typedef logic [`BIU_DATA_BYTES-1:0]     biu_sel_t;
    typedef logic [1:0]                     biu_len_t;
    typedef logic [1:0]                     biu_func_t;

    typedef logic [`WB_DATA_WIDTH-1:0]      wb_data_t;
    typedef logic [`WB_DATA_WIDTH/8-1:0]    wb_sel_t;
    typedef logic [2:0]                     wb_cti_t;
    typedef logic [1:0]                     wb_bte_t;

    // Request length codes
    localparam biu_len_t BIU_LEN_4B  = 2'd0;
    localparam biu_len_t BIU_LEN_8B  = 2'd1;
    localparam biu_len_t BIU_LEN_16B = 2'd2;

    // Request function codes
    localparam biu_func_t BIU_FUNC_READ  = 2'd0;
    localparam biu_func_t BIU_FUNC_WRITE = 2'd1;
    localparam biu_func_t BIU_FUNC_RMW   = 2'd2;

    // Wishbone B4 cycle type and burst type encodings
    localparam wb_cti_t WB_CTI_CLASSIC      = 3'b000;
    localparam wb_cti_t WB_CTI_INCREMENTING = 3'b010;
    localparam wb_cti_t WB_CTI_END_OF_BURST = 3'b111;
    localparam wb_bte_t WB_BTE_LINEAR       = 2'b00;

    typedef struct packed {
        biu_func_t func;
        biu_len_t  len;
        biu_sel_t  sel;
        biu_addr_t addr;
        biu_data_t data;
    } biu_req_t;

    typedef struct packed {
        biu_data_t data;
    } biu_rsp_t;

    typedef struct packed {
        logic      cyc;
        logic      stb;
        logic      we;
        wb_cti_t   cti;
        wb_bte_t   bte;
        wb_sel_t   sel;
        biu_addr_t addr;
        wb_data_t  data;
    } wb_m2s_t;

    typedef struct packed {
        logic     ack;
        wb_data_t data;
    } wb_s2m_t;

endpackage

// ==== hdl/biu_req_queue.sv ====
/* Request FIFO under credit flow control. A credit goes back in the same cycle
   as each pop, so the requester never sees the queue full */
`timescale 1ns/1ps
`include "biu_settings.svh"

module biu_req_queue (
    input  logic              i_wb_clk,
    input  logic              i_reset,
    input  logic              i_push,
    input  biu_pkg::biu_req_t i_req,
    input  logic              i_pop,
    output logic              o_valid,
    output biu_pkg::biu_req_t o_head,
    output logic              o_credit
);

    localparam int DEPTH = `REQ_QUEUE_DEPTH;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    biu_pkg::biu_req_t entries [DEPTH];
    logic [PTR_W-1:0]  wr_ptr_r;
    logic [PTR_W-1:0]  rd_ptr_r;
    logic [CNT_W-1:0]  count_r;
    logic              full;

    assign full     = (count_r == CNT_W'(DEPTH));
    assign o_valid  = (count_r != '0);
    assign o_head   = entries[rd_ptr_r];
    assign o_credit = i_pop && o_valid;

    // Payload storage
    always_ff @(posedge i_wb_clk) begin
        if (i_push) begin
            entries[wr_ptr_r] <= i_req;
        end
    end

    always_ff @(posedge i_wb_clk) begin
        if (i_reset) begin
            wr_ptr_r <= '0;
            rd_ptr_r <= '0;
            count_r  <= '0;
        end else begin
            if (i_push) begin
                wr_ptr_r <= (wr_ptr_r == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_r + PTR_W'(1);
            end
            if (i_pop) begin
                rd_ptr_r <= (rd_ptr_r == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_r + PTR_W'(1);
            end
            // Simultaneous push and pop leave the count alone
            if (i_push && !i_pop) begin
                count_r <= count_r + CNT_W'(1);
            end else if (!i_push && i_pop) begin
                count_r <= count_r - CNT_W'(1);
            end
        end
    end

    // The requester must respect its credits
    a_no_push_when_full: assert property (@(posedge i_wb_clk) disable iff (i_reset)
        i_push |-> !full);

    // The controller only pops a valid head
    a_no_pop_when_empty: assert property (@(posedge i_wb_clk) disable iff (i_reset)
        i_pop |-> o_valid);

endmodule

// ==== hdl/biu_settings.svh ====
/* Build-time sizes for the BIU and the SRAM model. REQ_QUEUE_DEPTH is also the
   number of credits the requester starts with */
`ifndef BIU_SETTINGS_SVH
`define BIU_SETTINGS_SVH

// Request payload width in bytes
`define BIU_DATA_BYTES 16

// Wishbone data port width in bits
`define WB_DATA_WIDTH 32

// Byte address width on both sides
`define BIU_ADDR_WIDTH 16

// Pending request entries, one credit each
`define REQ_QUEUE_DEPTH 4

// SRAM size in Wishbone words
`define SRAM_WORDS 256

// Extra cycles between the strobe being seen and the ack
`define SRAM_WAIT_STATES 1

`endif

// ==== hdl/biu_wb_top.sv ====
/* BIU with its request queue and an on-chip Wishbone SRAM as system memory.
   Responses cannot be stalled, the requester must take each one */
`timescale 1ns/1ps

module biu_wb_top (
    input  logic              i_wb_clk,
    input  logic              i_reset,
    input  logic              i_req_push,
    input  biu_pkg::biu_req_t i_req,
    output logic              o_credit,
    output logic              o_rsp_valid,
    output biu_pkg::biu_rsp_t o_rsp
);

    logic              q_valid;
    logic              q_pop;
    biu_pkg::biu_req_t q_head;
    biu_pkg::wb_m2s_t  wb_m2s;
    biu_pkg::wb_s2m_t  wb_s2m;

    biu_req_queue req_queue0 (
        .i_wb_clk (i_wb_clk),
        .i_reset  (i_reset),
        .i_push   (i_req_push),
        .i_req    (i_req),
        .i_pop    (q_pop),
        .o_valid  (q_valid),
        .o_head   (q_head),
        .o_credit (o_credit)
    );

    biu_controller_wb controller0 (
        .i_wb_clk    (i_wb_clk),
        .i_reset     (i_reset),
        .i_req_valid (q_valid),
        .i_req       (q_head),
        .i_wb        (wb_s2m),
        .o_req_pop   (q_pop),
        .o_wb        (wb_m2s),
        .o_rsp_valid (o_rsp_valid),
        .o_rsp       (o_rsp)
    );

    wb_sram sram0 (
        .i_wb_clk (i_wb_clk),
        .i_reset  (i_reset),
        .i_wb     (wb_m2s),
        .o_wb     (wb_s2m)
    );

endmodule

// ==== hdl/wb_sram.sv ====
/* Wishbone slave memory, ack after SRAM_WAIT_STATES+1 cycles per beat. Upper address
   bits beyond the SRAM size are ignored, so the memory aliases */
`timescale 1ns/1ps
`include "biu_settings.svh"

module wb_sram (
    input  logic             i_wb_clk,
    input  logic             i_reset,
    input  biu_pkg::wb_m2s_t i_wb,
    output biu_pkg::wb_s2m_t o_wb
);

    localparam int WORDS    = `SRAM_WORDS;
    localparam int AW       = $clog2(WORDS);
    localparam int WB_BYTES = `WB_DATA_WIDTH / 8;
    localparam int OFS      = $clog2(WB_BYTES);
    localparam int WAITS    = `SRAM_WAIT_STATES;
    localparam int WAIT_W   = (WAITS > 0) ? $clog2(WAITS + 1) : 1;

    biu_pkg::wb_data_t mem [WORDS];
    biu_pkg::wb_data_t rd_data_r;
    logic [AW-1:0]     word_addr;
    logic [WAIT_W-1:0] wait_cnt_r;
    logic              ack_r;
    logic              beat_done;

    assign word_addr = i_wb.addr[OFS +: AW];
    // Strobe in the ack cycle belongs to the beat just finished
    assign beat_done = i_wb.cyc && i_wb.stb && !ack_r && (wait_cnt_r == WAIT_W'(WAITS));

    always_ff @(posedge i_wb_clk) begin
        if (i_reset) begin
            ack_r      <= 1'b0;
            wait_cnt_r <= '0;
        end else begin
            ack_r <= beat_done;
            if (i_wb.cyc && i_wb.stb && !ack_r && !beat_done) begin
                wait_cnt_r <= wait_cnt_r + WAIT_W'(1);
            end else begin
                wait_cnt_r <= '0;
            end
        end
    end

    // Byte lane writes, read data registered with the ack
    always_ff @(posedge i_wb_clk) begin
        if (beat_done) begin
            if (i_wb.we) begin
                for (int b = 0; b < WB_BYTES; b++) begin
                    if (i_wb.sel[b]) begin
                        mem[word_addr][b*8 +: 8] <= i_wb.data[b*8 +: 8];
                    end
                end
            end
            rd_data_r <= mem[word_addr];
        end
    end

    assign o_wb.ack  = ack_r;
    assign o_wb.data = rd_data_r;

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the BIU testbench with Verilator, pass/fail taken from the log
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timing --timescale 1ns/1ps \
    -f biu_wb_top.f --top-module biu_wb_tb -o sim_biu

./obj_dir/sim_biu | tee sim.log

if grep -q "^Test OK$" sim.log; then
    echo "Simulation passed"
    exit 0
fi
echo "Simulation failed, see sim.log"
exit 1
